/* compile.f */
+incdir+hw
hw/lsu_pkg.sv
hw/str_entry.sv
hw/str_alloc.sv
hw/str_drain.sv
hw/load_unit.sv
hw/ls_arbiter.sv
hw/data_mem.sv
hw/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

/* dv/lsu_checker.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_checker (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           st_alloc,
   input  lsu_pkg::addr_t st_addr,
   input  lsu_pkg::data_t st_data,
   input  lsu_pkg::tag_t  st_tag,
   input  logic           st_cmmt,
   input  logic           flsh,
   input  logic           ld_req,
   input  lsu_pkg::addr_t ld_addr,
   input  lsu_pkg::tag_t  ld_tag,
   input  logic           stll,
   input  logic           ld_vld,
   input  lsu_pkg::data_t ld_data,
   input  lsu_pkg::tag_t  ld_tag_out,
   input  logic           st_iss,
   input  lsu_pkg::tag_t  st_iss_tag,
   output int             val_errs,
   output int             proto_errs,
   output int             sq_cnt,
   output int             cmt_pend
);
   import lsu_pkg::*;

   localparam int DEPTH   = `LSU_SQ_DEPTH;
   localparam int WORDS   = 1 << `LSU_MEM_AW;
   localparam int MEM_LAT = `LSU_MEM_LAT;

   // Store queue model, oldest at index 0
   addr_t q_addr[$];
   data_t q_data[$];
   tag_t  q_tag[$];
   int    n_cmt;
   int    q_len;
   data_t mem_m [WORDS];

   logic  ld_out;
   logic  exp_hit;
   logic  exp_stll;
   data_t exp_data;
   tag_t  exp_tag;
   addr_t exp_addr;
   addr_t iss_a;
   int    req_cyc;
   int    cyc;
   int    n_val;
   int    n_proto;

   initial begin
      cyc     = 0;
      n_val   = 0;
      n_proto = 0;
      n_cmt   = 0;
      q_len   = 0;
      ld_out  = 1'b0;
      for (int i = 0; i < WORDS; i++) begin
         mem_m[i] = '0;
      end
   end

   assign val_errs   = n_val;
   assign proto_errs = n_proto;
   assign sq_cnt     = q_len;
   assign cmt_pend   = n_cmt;

   // Youngest queued store to the same address, else the memory word
   function automatic data_t ref_load(input addr_t a, output logic hit);
      data_t d;
      d   = mem_m[a[`LSU_MEM_AW-1:0]];
      hit = 1'b0;
      for (int i = q_addr.size() - 1; i >= 0; i--) begin
         if (!hit && (q_addr[i] == a)) begin
            hit = 1'b1;
            d   = q_data[i];
         end
      end
      return d;
   endfunction

   task automatic check_load();
      int lat;
      lat = cyc - req_cyc;
      if (ld_data !== exp_data) begin
         $display("FAIL ld_data: got 0x%04h expected 0x%04h (addr 0x%04h)",
                  ld_data, exp_data, exp_addr);
         n_val++;
      end
      if (ld_tag_out !== exp_tag) begin
         $display("FAIL ld_tag_out: got 0x%02h expected 0x%02h", ld_tag_out, exp_tag);
         n_val++;
      end
      // Forwarded loads have a fixed latency, memory loads a minimum
      if (exp_hit && (lat != 2)) begin
         $display("FAIL ld_vld latency: got 0x%0h expected 0x2", lat);
         n_val++;
      end
      if (!exp_hit && (lat < MEM_LAT + 3)) begin
         $display("FAIL ld_vld latency: got 0x%0h expected at least 0x%0h", lat, MEM_LAT + 3);
         n_val++;
      end
   endtask

   ////////////////////
   // Compare and update
   ////////////////////

   always @(posedge clk) begin
      cyc = cyc + 1;
      if (!rst_n) begin
         q_addr.delete();
         q_data.delete();
         q_tag.delete();
         n_cmt  = 0;
         ld_out = 1'b0;
      end else begin
         exp_stll = (q_addr.size() == DEPTH) || ld_out;
         if (stll !== exp_stll) begin
            $display("FAIL stll: got 0x%0h expected 0x%0h at cycle %0d", stll, exp_stll, cyc);
            n_val++;
         end
         if (ld_vld) begin
            if (!ld_out) begin
               $display("Load result pulsed at cycle %0d with no load outstanding", cyc);
               n_proto++;
            end else begin
               check_load();
               ld_out = 1'b0;
            end
         end
         // Search sees only stores allocated before this edge
         if (ld_req) begin
            if (ld_out) begin
               $display("Load request at cycle %0d while another load was in flight", cyc);
               n_proto++;
            end
            exp_data = ref_load(ld_addr, exp_hit);
            exp_addr = ld_addr;
            exp_tag  = ld_tag;
            req_cyc  = cyc;
            ld_out   = 1'b1;
         end
         if (st_iss) begin
            if (n_cmt == 0) begin
               $display("Store issued at cycle %0d with no committed store pending", cyc);
               n_proto++;
            end else begin
               if (st_iss_tag !== q_tag[0]) begin
                  $display("FAIL st_iss_tag: got 0x%02h expected 0x%02h", st_iss_tag, q_tag[0]);
                  n_val++;
               end
               iss_a = q_addr[0];
               mem_m[iss_a[`LSU_MEM_AW-1:0]] = q_data[0];
               void'(q_addr.pop_front());
               void'(q_data.pop_front());
               void'(q_tag.pop_front());
               n_cmt--;
            end
         end
         if (st_cmmt && (n_cmt < q_addr.size())) begin
            n_cmt++;
         end
         if (st_alloc) begin
            if (q_addr.size() == DEPTH) begin
               $display("Store allocated at cycle %0d while the queue was full", cyc);
               n_proto++;
            end
            q_addr.push_back(st_addr);
            q_data.push_back(st_data);
            q_tag.push_back(st_tag);
         end
         // Uncommitted stores sit at the young end
         if (flsh) begin
            while (q_addr.size() > n_cmt) begin
               void'(q_addr.pop_back());
               void'(q_data.pop_back());
               void'(q_tag.pop_back());
            end
         end
      end
      q_len = q_addr.size();
   end

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;
   import lsu_pkg::*;

   localparam int DEPTH      = `LSU_SQ_DEPTH;
   localparam int WAIT_LIMIT = 200;
   localparam int RAND_OPS   = 300;

   logic  clk;
   logic  rst_n;
   logic  st_alloc;
   addr_t st_addr;
   data_t st_data;
   tag_t  st_tag;
   logic  st_cmmt;
   logic  flsh;
   logic  ld_req;
   addr_t ld_addr;
   tag_t  ld_tag;
   logic  stll;
   logic  ld_vld;
   data_t ld_data;
   tag_t  ld_tag_out;
   logic  st_iss;
   tag_t  st_iss_tag;
   int    val_errs;
   int    proto_errs;
   int    sq_cnt;
   int    cmt_pend;
   int    tmo_errs;
   tag_t  next_tag;
   int    op_i;
   int    pick;
   int    seed;

   always #2 clk = ~clk;

   lsu_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .st_alloc   (st_alloc),
      .st_addr    (st_addr),
      .st_data    (st_data),
      .st_tag     (st_tag),
      .st_cmmt    (st_cmmt),
      .flsh       (flsh),
      .ld_req     (ld_req),
      .ld_addr    (ld_addr),
      .ld_tag     (ld_tag),
      .stll       (stll),
      .ld_vld     (ld_vld),
      .ld_data    (ld_data),
      .ld_tag_out (ld_tag_out),
      .st_iss     (st_iss),
      .st_iss_tag (st_iss_tag)
   );

   lsu_checker chk (
      .clk        (clk),
      .rst_n      (rst_n),
      .st_alloc   (st_alloc),
      .st_addr    (st_addr),
      .st_data    (st_data),
      .st_tag     (st_tag),
      .st_cmmt    (st_cmmt),
      .flsh       (flsh),
      .ld_req     (ld_req),
      .ld_addr    (ld_addr),
      .ld_tag     (ld_tag),
      .stll       (stll),
      .ld_vld     (ld_vld),
      .ld_data    (ld_data),
      .ld_tag_out (ld_tag_out),
      .st_iss     (st_iss),
      .st_iss_tag (st_iss_tag),
      .val_errs   (val_errs),
      .proto_errs (proto_errs),
      .sq_cnt     (sq_cnt),
      .cmt_pend   (cmt_pend)
   );

   task automatic finish_run();
      $display("Errors: value %0d, protocol %0d, timeout %0d", val_errs, proto_errs, tmo_errs);
      if ((val_errs + proto_errs + tmo_errs) == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   ////////////////////
   // Bus operations
   ////////////////////

   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk);
      while (stll && (n < WAIT_LIMIT)) begin
         @(negedge clk);
         n++;
      end
      if (stll) begin
         $display("Timeout: stall stayed high for %0d cycles", WAIT_LIMIT);
         tmo_errs++;
         finish_run();
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      @(negedge clk);
      while ((cmt_pend != 0) && (n < WAIT_LIMIT)) begin
         @(negedge clk);
         n++;
      end
      if (cmt_pend != 0) begin
         $display("Timeout: committed stores still waiting after %0d cycles", WAIT_LIMIT);
         tmo_errs++;
         finish_run();
      end
   endtask

   task automatic store_op(input addr_t a, input data_t d);
      wait_ready();
      @(posedge clk);
      st_alloc <= 1'b1;
      st_addr  <= a;
      st_data  <= d;
      st_tag   <= next_tag;
      next_tag = next_tag + 1'b1;
      @(posedge clk);
      st_alloc <= 1'b0;
   endtask

   task automatic commit_op();
      @(posedge clk);
      st_cmmt <= 1'b1;
      @(posedge clk);
      st_cmmt <= 1'b0;
   endtask

   task automatic flush_op();
      @(posedge clk);
      flsh <= 1'b1;
      @(posedge clk);
      flsh <= 1'b0;
   endtask

   task automatic load_op(input addr_t a);
      int n;
      n = 0;
      wait_ready();
      @(posedge clk);
      ld_req  <= 1'b1;
      ld_addr <= a;
      ld_tag  <= tag_t'($urandom);
      @(posedge clk);
      ld_req <= 1'b0;
      @(negedge clk);
      while (!ld_vld && (n < WAIT_LIMIT)) begin
         @(negedge clk);
         n++;
      end
      if (!ld_vld) begin
         $display("Timeout: no load result for address 0x%04h", a);
         tmo_errs++;
         finish_run();
      end
   endtask

   // A full queue of uncommitted stores would stall forever
   task automatic make_room();
      if (sq_cnt == DEPTH) begin
         commit_op();
      end
   endtask

   function automatic addr_t pool_addr(input int unsigned k);
      return addr_t'(16'h0040 + 4 * (k % 8));
   endfunction

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      st_alloc = 1'b0;
      st_addr  = '0;
      st_data  = '0;
      st_tag   = '0;
      st_cmmt  = 1'b0;
      flsh     = 1'b0;
      ld_req   = 1'b0;
      ld_addr  = '0;
      ld_tag   = '0;
      tmo_errs = 0;
      next_tag = '0;
      seed     = 32'ha454_258a;
      void'($urandom(seed));
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);

      // Younger of two stores forwards
      store_op(16'h0040, 16'h1111);
      store_op(16'h0040, 16'h2222);
      load_op(16'h0040);
      load_op(16'h0080);
      commit_op();
      commit_op();
      wait_drain();
      // Now served from memory
      load_op(16'h0040);

      // Third store stays uncommitted and must not issue
      store_op(16'h0044, 16'h4444);
      store_op(16'h0048, 16'h4848);
      store_op(16'h004c, 16'h4c4c);
      commit_op();
      commit_op();
      repeat (30) @(posedge clk);
      flush_op();
      wait_drain();
      load_op(16'h004c);

      // Committed store survives the flush, the younger one is dropped
      store_op(16'h0050, 16'h5050);
      commit_op();
      store_op(16'h0044, 16'hdead);
      store_op(16'h0054, 16'hbeef);
      flush_op();
      load_op(16'h0044);
      load_op(16'h0054);
      wait_drain();
      load_op(16'h0050);

      // Fill the queue, stall holds until a store drains
      for (op_i = 0; op_i < DEPTH; op_i++) begin
         store_op(pool_addr(op_i), data_t'(16'h7000 + op_i));
      end
      repeat (12) @(posedge clk);
      commit_op();
      wait_ready();
      repeat (DEPTH) commit_op();
      wait_drain();

      // Random mix
      for (op_i = 0; op_i < RAND_OPS; op_i++) begin
         @(negedge clk);
         pick = $urandom % 16;
         if (pick < 6) begin
            make_room();
            store_op(pool_addr($urandom), data_t'($urandom));
         end else if (pick < 10) begin
            commit_op();
         end else if (pick < 11) begin
            flush_op();
         end else begin
            make_room();
            load_op(pool_addr($urandom));
         end
      end
      repeat (DEPTH) commit_op();
      wait_drain();
      for (op_i = 0; op_i < 8; op_i++) begin
         load_op(pool_addr(op_i));
      end
      repeat (10) @(posedge clk);
      finish_run();
   end

endmodule

/* hw/data_mem.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_mem (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   mem_en,
   input  logic                   mem_we,
   input  logic [`LSU_ADDR_W-1:0] mem_addr,
   input  logic [`LSU_DATA_W-1:0] mem_wdata,
   output logic                   mem_done,
   output logic [`LSU_DATA_W-1:0] mem_rdata
);

   localparam int WORDS = 1 << `LSU_MEM_AW;
   localparam int LAT   = `LSU_MEM_LAT;

   logic [`LSU_DATA_W-1:0] mem [WORDS] = '{default: '0};
   logic [LAT-1:0]         lat_sr;
   logic [`LSU_MEM_AW-1:0] idx;

   // Word index from the low address bits
   assign idx = mem_addr[`LSU_MEM_AW-1:0];

   // Array access at enable
   always_ff @(posedge clk) begin
      if (mem_en && mem_we) begin
         mem[idx] <= mem_wdata;
      end
      if (mem_en && !mem_we) begin
         mem_rdata <= mem[idx];
      end
   end

   // Fixed latency to done
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lat_sr <= '0;
      end else begin
         lat_sr[0] <= mem_en;
         for (int i = 1; i < LAT; i++) begin
            lat_sr[i] <= lat_sr[i-1];
         end
      end
   end

   assign mem_done = lat_sr[LAT-1];

endmodule

/* hw/load_unit.sv */
`timescale 1ns/1ps

module load_unit (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           ld_req,
   input  lsu_pkg::addr_t ld_addr,
   input  lsu_pkg::tag_t  ld_tag,
   input  logic           fwd_hit,
   input  lsu_pkg::data_t fwd_data,
   input  logic           ld_grnt,
   input  logic           mem_done,
   input  lsu_pkg::data_t mem_rdata,
   output logic           ld_busy,
   output logic           ld_mem_req,
   output lsu_pkg::addr_t ld_mem_addr,
   output logic           ld_vld,
   output lsu_pkg::data_t ld_data,
   output lsu_pkg::tag_t  ld_tag_out
);
   import lsu_pkg::*;

   typedef enum logic [1:0] {
      ls_idle,
      ls_lookup,
      ls_mem_wait,
      ls_reply
   } ld_state_e;

   ld_state_e state;
   addr_t     addr_r;
   tag_t      tag_r;
   data_t     data_r;
   logic      rd_back;

   // Memory read finished under our own grant
   assign rd_back = (state == ls_mem_wait) && ld_grnt && mem_done;

   ////////////////////
   // Load FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ls_idle;
      end else begin
         case (state)
            ls_idle: begin
               if (ld_req) begin
                  state <= ls_lookup;
               end
            end
            // Search result is registered and visible here
            ls_lookup: begin
               state <= fwd_hit ? ls_reply : ls_mem_wait;
            end
            ls_mem_wait: begin
               if (rd_back) begin
                  state <= ls_reply;
               end
            end
            ls_reply: begin
               state <= ls_idle;
            end
            default: begin
               state <= ls_idle;
            end
         endcase
      end
   end

   // Request capture and result
   always_ff @(posedge clk) begin
      if ((state == ls_idle) && ld_req) begin
         addr_r <= ld_addr;
         tag_r  <= ld_tag;
      end
      if ((state == ls_lookup) && fwd_hit) begin
         data_r <= fwd_data;
      end else if (rd_back) begin
         data_r <= mem_rdata;
      end
   end

   assign ld_busy     = (state != ls_idle);
   // Ask for the port already in lookup on a miss
   assign ld_mem_req  = ((state == ls_lookup) && !fwd_hit) ||
                        ((state == ls_mem_wait) && !ld_grnt);
   assign ld_mem_addr = addr_r;
   assign ld_vld      = (state == ls_reply);
   assign ld_data     = data_r;
   assign ld_tag_out  = tag_r;

endmodule

/* hw/ls_arbiter.sv */
`timescale 1ns/1ps

module ls_arbiter (
   input  logic clk,
   input  logic rst_n,
   input  logic ld_mem_req,
   input  logic iss_req,
   input  logic mem_done,
   output logic ld_grnt,
   output logic st_grnt,
   output logic addr_sel,
   output logic mem_en,
   output logic mem_we,
   output logic st_done
);

   typedef enum logic {
      arb_idle,
      arb_busy
   } arb_state_e;

   arb_state_e state;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= arb_idle;
         ld_grnt <= 1'b0;
         st_grnt <= 1'b0;
         mem_en  <= 1'b0;
         mem_we  <= 1'b0;
      end else begin
         // Enable is a single cycle per grant
         mem_en <= 1'b0;
         mem_we <= 1'b0;
         case (state)
            arb_idle: begin
               // Loads first
               if (ld_mem_req) begin
                  ld_grnt <= 1'b1;
                  mem_en  <= 1'b1;
                  state   <= arb_busy;
               end else if (iss_req) begin
                  st_grnt <= 1'b1;
                  mem_en  <= 1'b1;
                  mem_we  <= 1'b1;
                  state   <= arb_busy;
               end
            end
            arb_busy: begin
               if (mem_done) begin
                  ld_grnt <= 1'b0;
                  st_grnt <= 1'b0;
                  state   <= arb_idle;
               end
            end
            default: begin
               state <= arb_idle;
            end
         endcase
      end
   end

   assign addr_sel = st_grnt;
   assign st_done  = st_grnt && mem_done;

endmodule

/* hw/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

////////////////////
// Store queue
////////////////////

`define LSU_SQ_DEPTH 4

////////////////////
// Datapath widths
////////////////////

`define LSU_ADDR_W 16
`define LSU_DATA_W 16
`define LSU_TAG_W  6

// 256 words, indexed by the low address bits
`define LSU_MEM_AW  8
// Enable to done
`define LSU_MEM_LAT 3

`endif

/* hw/lsu_pkg.sv */
`include "lsu_cfg.svh"

package lsu_pkg;

   // Load or store address
   typedef logic [`LSU_ADDR_W-1:0] addr_t;

   // Data word
   typedef logic [`LSU_DATA_W-1:0] data_t;

   // Instruction tag
   typedef logic [`LSU_TAG_W-1:0] tag_t;

   // Queue pointer, top bit is the wrap flag
   typedef logic [$clog2(`LSU_SQ_DEPTH):0] sq_ptr_t;

endpackage

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           st_alloc,
   input  lsu_pkg::addr_t st_addr,
   input  lsu_pkg::data_t st_data,
   input  lsu_pkg::tag_t  st_tag,
   input  logic           st_cmmt,
   input  logic           flsh,
   input  logic           ld_req,
   input  lsu_pkg::addr_t ld_addr,
   input  lsu_pkg::tag_t  ld_tag,
   output logic           stll,
   output logic           ld_vld,
   output lsu_pkg::data_t ld_data,
   output lsu_pkg::tag_t  ld_tag_out,
   output logic           st_iss,
   output lsu_pkg::tag_t  st_iss_tag
);
   import lsu_pkg::*;

   localparam int DEPTH = `LSU_SQ_DEPTH;

   logic [DEPTH-1:0]             wr_en;
   logic [DEPTH-1:0]             cmmt_en;
   logic [DEPTH-1:0]             clr_en;
   sq_ptr_t                      head_ptr;
   logic                         sq_full;
   logic [DEPTH-1:0]             e_vld;
   logic [DEPTH-1:0]             e_cmtd;
   logic [DEPTH*`LSU_ADDR_W-1:0] e_addr;
   logic [DEPTH*`LSU_DATA_W-1:0] e_data;
   logic [DEPTH*`LSU_TAG_W-1:0]  e_tag;
   logic                         fwd_hit;
   data_t                        fwd_data;
   logic                         iss_req;
   addr_t                        iss_addr;
   data_t                        iss_data;
   tag_t                         iss_tag;
   logic                         ld_busy;
   logic                         ld_mem_req;
   addr_t                        ld_mem_addr;
   logic                         ld_grnt;
   logic                         addr_sel;
   logic                         mem_en;
   logic                         mem_we;
   logic                         st_done;
   logic                         mem_done;
   data_t                        mem_rdata;
   addr_t                        mem_addr;

   ////////////////////
   // Store queue
   ////////////////////

   str_alloc u_alloc (
      .clk      (clk),
      .rst_n    (rst_n),
      .st_alloc (st_alloc),
      .st_cmmt  (st_cmmt),
      .flsh     (flsh),
      .st_done  (st_done),
      .wr_en    (wr_en),
      .cmmt_en  (cmmt_en),
      .clr_en   (clr_en),
      .head_ptr (head_ptr),
      .sq_full  (sq_full)
   );

   for (genvar i = 0; i < DEPTH; i++) begin : g_sq
      str_entry u_entry (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr_en   (wr_en[i]),
         .cmmt_en (cmmt_en[i]),
         .clr_en  (clr_en[i]),
         .flsh    (flsh),
         .wr_addr (st_addr),
         .wr_data (st_data),
         .wr_tag  (st_tag),
         .vld     (e_vld[i]),
         .cmtd    (e_cmtd[i]),
         .addr    (e_addr[i*`LSU_ADDR_W +: `LSU_ADDR_W]),
         .data    (e_data[i*`LSU_DATA_W +: `LSU_DATA_W]),
         .tag     (e_tag[i*`LSU_TAG_W +: `LSU_TAG_W])
      );
   end

   str_drain u_drain (
      .clk      (clk),
      .rst_n    (rst_n),
      .ld_req   (ld_req),
      .ld_addr  (ld_addr),
      .head_ptr (head_ptr),
      .e_vld    (e_vld),
      .e_cmtd   (e_cmtd),
      .e_addr   (e_addr),
      .e_data   (e_data),
      .e_tag    (e_tag),
      .fwd_hit  (fwd_hit),
      .fwd_data (fwd_data),
      .iss_req  (iss_req),
      .iss_addr (iss_addr),
      .iss_data (iss_data),
      .iss_tag  (iss_tag)
   );

   ////////////////////
   // Loads and memory
   ////////////////////

   load_unit u_load (
      .clk         (clk),
      .rst_n       (rst_n),
      .ld_req      (ld_req),
      .ld_addr     (ld_addr),
      .ld_tag      (ld_tag),
      .fwd_hit     (fwd_hit),
      .fwd_data    (fwd_data),
      .ld_grnt     (ld_grnt),
      .mem_done    (mem_done),
      .mem_rdata   (mem_rdata),
      .ld_busy     (ld_busy),
      .ld_mem_req  (ld_mem_req),
      .ld_mem_addr (ld_mem_addr),
      .ld_vld      (ld_vld),
      .ld_data     (ld_data),
      .ld_tag_out  (ld_tag_out)
   );

   ls_arbiter u_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .ld_mem_req (ld_mem_req),
      .iss_req    (iss_req),
      .mem_done   (mem_done),
      .ld_grnt    (ld_grnt),
      .st_grnt    (),
      .addr_sel   (addr_sel),
      .mem_en     (mem_en),
      .mem_we     (mem_we),
      .st_done    (st_done)
   );

   // Store address while the store holds the port
   assign mem_addr = addr_sel ? iss_addr : ld_mem_addr;

   data_mem u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (iss_data),
      .mem_done  (mem_done),
      .mem_rdata (mem_rdata)
   );

   assign stll       = sq_full | ld_busy;
   assign st_iss     = st_done;
   assign st_iss_tag = iss_tag;

endmodule

/* hw/str_alloc.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module str_alloc (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     st_alloc,
   input  logic                     st_cmmt,
   input  logic                     flsh,
   input  logic                     st_done,
   output logic [`LSU_SQ_DEPTH-1:0] wr_en,
   output logic [`LSU_SQ_DEPTH-1:0] cmmt_en,
   output logic [`LSU_SQ_DEPTH-1:0] clr_en,
   output lsu_pkg::sq_ptr_t         head_ptr,
   output logic                     sq_full
);
   import lsu_pkg::*;

   localparam int IDX_W = $clog2(`LSU_SQ_DEPTH);

   sq_ptr_t cmt_ptr;
   sq_ptr_t tail_ptr;
   sq_ptr_t cmt_nxt;
   logic    do_alloc;
   logic    do_cmmt;

   // A store arriving together with a flush is dropped
   assign do_alloc = st_alloc && !sq_full && !flsh;
   // Nothing to commit when every allocated store is committed
   assign do_cmmt  = st_cmmt && (cmt_ptr != tail_ptr);
   assign cmt_nxt  = do_cmmt ? cmt_ptr + 1'b1 : cmt_ptr;

   // One-hot slot enables
   always_comb begin
      wr_en   = '0;
      cmmt_en = '0;
      clr_en  = '0;
      wr_en[tail_ptr[IDX_W-1:0]]  = do_alloc;
      cmmt_en[cmt_ptr[IDX_W-1:0]] = do_cmmt;
      clr_en[head_ptr[IDX_W-1:0]] = st_done;
   end

   ////////////////////
   // Pointers
   ////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head_ptr <= '0;
         cmt_ptr  <= '0;
         tail_ptr <= '0;
      end else begin
         if (st_done) begin
            head_ptr <= head_ptr + 1'b1;
         end
         cmt_ptr <= cmt_nxt;
         // Flush pulls the tail back over the uncommitted stores
         if (flsh) begin
            tail_ptr <= cmt_nxt;
         end else if (do_alloc) begin
            tail_ptr <= tail_ptr + 1'b1;
         end
      end
   end

   assign sq_full = (head_ptr[IDX_W-1:0] == tail_ptr[IDX_W-1:0]) &&
                    (head_ptr[IDX_W] != tail_ptr[IDX_W]);

endmodule

/* hw/str_drain.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module str_drain (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 ld_req,
   input  lsu_pkg::addr_t                       ld_addr,
   input  lsu_pkg::sq_ptr_t                     head_ptr,
   input  logic [`LSU_SQ_DEPTH-1:0]             e_vld,
   input  logic [`LSU_SQ_DEPTH-1:0]             e_cmtd,
   input  logic [`LSU_SQ_DEPTH*`LSU_ADDR_W-1:0] e_addr,
   input  logic [`LSU_SQ_DEPTH*`LSU_DATA_W-1:0] e_data,
   input  logic [`LSU_SQ_DEPTH*`LSU_TAG_W-1:0]  e_tag,
   output logic                                 fwd_hit,
   output lsu_pkg::data_t                       fwd_data,
   output logic                                 iss_req,
   output lsu_pkg::addr_t                       iss_addr,
   output lsu_pkg::data_t                       iss_data,
   output lsu_pkg::tag_t                        iss_tag
);
   import lsu_pkg::*;

   localparam int DEPTH = `LSU_SQ_DEPTH;
   localparam int IDX_W = $clog2(DEPTH);

   logic [IDX_W-1:0] head_idx;
   logic [IDX_W-1:0] scan_idx;
   logic             srch_hit;
   data_t            srch_data;

   assign head_idx = head_ptr[IDX_W-1:0];

   ////////////////////
   // Forwarding search
   ////////////////////

   // Valid slots run contiguously from the head, so scanning oldest to
   // youngest and keeping the last match yields the youngest store
   always_comb begin
      srch_hit  = 1'b0;
      srch_data = '0;
      scan_idx  = head_idx;
      for (int k = 0; k < DEPTH; k++) begin
         scan_idx = head_idx + IDX_W'(k);
         if (e_vld[scan_idx] &&
             (e_addr[scan_idx*`LSU_ADDR_W +: `LSU_ADDR_W] == ld_addr)) begin
            srch_hit  = 1'b1;
            srch_data = e_data[scan_idx*`LSU_DATA_W +: `LSU_DATA_W];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fwd_hit <= 1'b0;
      end else begin
         fwd_hit <= ld_req && srch_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_req) begin
         fwd_data <= srch_data;
      end
   end

   ////////////////////
   // Store issue
   ////////////////////

   // Oldest store goes out once committed
   assign iss_req  = e_vld[head_idx] && e_cmtd[head_idx];
   assign iss_addr = e_addr[head_idx*`LSU_ADDR_W +: `LSU_ADDR_W];
   assign iss_data = e_data[head_idx*`LSU_DATA_W +: `LSU_DATA_W];
   assign iss_tag  = e_tag[head_idx*`LSU_TAG_W +: `LSU_TAG_W];

endmodule

/* hw/str_entry.sv */
`timescale 1ns/1ps

module str_entry (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           wr_en,
   input  logic           cmmt_en,
   input  logic           clr_en,
   input  logic           flsh,
   input  lsu_pkg::addr_t wr_addr,
   input  lsu_pkg::data_t wr_data,
   input  lsu_pkg::tag_t  wr_tag,
   output logic           vld,
   output logic           cmtd,
   output lsu_pkg::addr_t addr,
   output lsu_pkg::data_t data,
   output lsu_pkg::tag_t  tag
);
   import lsu_pkg::*;

   addr_t addr_r;
   data_t data_r;
   tag_t  tag_r;

   // Slot state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld  <= 1'b0;
         cmtd <= 1'b0;
      end else if (clr_en) begin
         // Written to memory, slot is free again
         vld  <= 1'b0;
         cmtd <= 1'b0;
      end else if (wr_en) begin
         vld  <= 1'b1;
         cmtd <= 1'b0;
      end else begin
         if (cmmt_en) begin
            cmtd <= 1'b1;
         end
         // A commit on the flush edge still counts
         if (flsh && !cmtd && !cmmt_en) begin
            vld <= 1'b0;
         end
      end
   end

   // Store payload
   always_ff @(posedge clk) begin
      if (wr_en) begin
         addr_r <= wr_addr;
         data_r <= wr_data;
         tag_r  <= wr_tag;
      end
   end

   assign addr = addr_r;
   assign data = data_r;
   assign tag  = tag_r;

endmodule
